// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ant_engine
FILELIST = filelist.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+hw
hw/ant_pkg.sv
hw/dp_arbiter.sv
hw/ant_update.sv
hw/ant_draw.sv
hw/ant_engine.sv
testbench/ant_engine_properties.sv
testbench/tb_ant_engine.sv

// ==== hw/ant_draw.sv ====
`timescale 1ns/1ps
`include "ant_params.svh"

module ant_draw
    import ant_pkg::*;
(
    input  logic    clock,
    input  logic    resetn,
    input  logic    start,
    input  ant_id_t ant_id,
    input  logic    finished_dp,
    input  result_t result_dp,
    output logic    finished,
    output logic    start_dp,
    output instr_t  instruction_dp
);

    draw_state_t state;
    draw_state_t ret_state;

    // sprite origin at the top left corner
    x_coord_t org_x;
    y_coord_t org_y;
    logic [$clog2(`ANT_WIDTH)-1:0]  col;
    logic [$clog2(`ANT_HEIGHT)-1:0] row;

    x_coord_t  pix_x;
    y_coord_t  pix_y;
    mem_addr_t ant_x_addr;
    mem_addr_t ant_y_addr;

    assign ant_x_addr = mem_addr_t'(`ANT_X_BASE) + mem_addr_t'(ant_id);
    assign ant_y_addr = mem_addr_t'(`ANT_Y_BASE) + mem_addr_t'(ant_id);
    assign pix_x      = org_x + x_coord_t'(col);
    assign pix_y      = org_y + y_coord_t'(row);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state          <= D_STANDBY;
            ret_state      <= D_STANDBY;
            finished       <= 1'b1;
            col            <= '0;
            row            <= '0;
            start_dp       <= 1'b0;
            instruction_dp <= '0;
        end else begin
            start_dp <= 1'b0;
            case (state)
                D_STANDBY: begin
                    if (start) begin
                        finished       <= 1'b0;
                        start_dp       <= 1'b1;
                        instruction_dp <= instr_t'({ant_x_addr, OP_MEMREAD});
                        ret_state      <= D_X_WAIT;
                        state          <= D_DELAY;
                    end
                end
                D_DELAY: begin
                    start_dp <= 1'b1;
                    state    <= ret_state;
                end
                D_X_WAIT: begin
                    if (finished_dp) begin
                        org_x          <= result_dp - 1'b1;
                        start_dp       <= 1'b1;
                        instruction_dp <= instr_t'({ant_y_addr, OP_MEMREAD});
                        ret_state      <= D_Y_WAIT;
                        state          <= D_DELAY;
                    end
                end
                D_Y_WAIT: begin
                    if (finished_dp) begin
                        org_y <= result_dp[`Y_COORD_WIDTH-1:0] - 1'b1;
                        col   <= '0;
                        row   <= '0;
                        state <= D_PIXEL;
                    end
                end
                D_PIXEL: begin
                    start_dp       <= 1'b1;
                    instruction_dp <= instr_t'({1'b1, colour_t'(`ANT_COLOUR), pix_y, pix_x,
                                                OP_DRAW});
                    ret_state      <= D_PIXEL_WAIT;
                    state          <= D_DELAY;
                end
                D_PIXEL_WAIT: begin
                    // row-major walk with column fastest
                    if (finished_dp) begin
                        state <= D_PIXEL;
                        col   <= col + 1'b1;
                        if (col == ($clog2(`ANT_WIDTH))'(`ANT_WIDTH - 1)) begin
                            row <= row + 1'b1;
                            if (row == ($clog2(`ANT_HEIGHT))'(`ANT_HEIGHT - 1)) begin
                                finished <= 1'b1;
                                state    <= D_STANDBY;
                            end
                        end
                    end
                end
                default: state <= D_STANDBY;
            endcase
        end
    end

endmodule

// ==== hw/ant_engine.sv ====
`timescale 1ns/1ps

module ant_engine
    import ant_pkg::*;
(
    input  logic        clock,
    input  logic        resetn,
    input  logic        update_start,
    input  logic        draw_start,
    input  ant_id_t     ant_id,
    input  logic        finished_dp,
    input  result_t     result_dp,
    output logic        update_finished,
    output logic        draw_finished,
    output food_index_t closest_food,
    output logic        start_dp,
    output instr_t      instruction_dp
);

    // client side of the arbiter
    logic    update_start_dp;
    instr_t  update_instruction;
    logic    update_finished_dp;
    result_t update_result;
    logic    draw_start_dp;
    instr_t  draw_instruction;
    logic    draw_finished_dp;
    result_t draw_result;

    ant_update i_ant_update (
        .clock          (clock),
        .resetn         (resetn),
        .start          (update_start),
        .ant_id         (ant_id),
        .finished_dp    (update_finished_dp),
        .result_dp      (update_result),
        .finished       (update_finished),
        .closest_food   (closest_food),
        .start_dp       (update_start_dp),
        .instruction_dp (update_instruction)
    );

    ant_draw i_ant_draw (
        .clock          (clock),
        .resetn         (resetn),
        .start          (draw_start),
        .ant_id         (ant_id),
        .finished_dp    (draw_finished_dp),
        .result_dp      (draw_result),
        .finished       (draw_finished),
        .start_dp       (draw_start_dp),
        .instruction_dp (draw_instruction)
    );

    dp_arbiter i_dp_arbiter (
        .clock              (clock),
        .resetn             (resetn),
        .update_start_dp    (update_start_dp),
        .update_instruction (update_instruction),
        .draw_start_dp      (draw_start_dp),
        .draw_instruction   (draw_instruction),
        .finished_dp        (finished_dp),
        .result_dp          (result_dp),
        .update_finished_dp (update_finished_dp),
        .update_result      (update_result),
        .draw_finished_dp   (draw_finished_dp),
        .draw_result        (draw_result),
        .start_dp           (start_dp),
        .instruction_dp     (instruction_dp)
    );

endmodule

// ==== hw/ant_params.svh ====
`ifndef ANT_PARAMS_SVH
`define ANT_PARAMS_SVH

// screen coordinates
`define X_COORD_WIDTH 8
`define Y_COORD_WIDTH 7
`define SCREEN_WIDTH 160
`define SCREEN_HEIGHT 120

// ant sprite
`define ANT_WIDTH 4
`define ANT_HEIGHT 4
`define ANT_ID_WIDTH 3
`define COLOUR_WIDTH 3
`define ANT_COLOUR 3'b101

// food items visited by one update scan
`define NUM_FOOD 4

// datapath bus
`define MEM_ADDR_WIDTH 8
`define RESULT_WIDTH 8
`define INSTRUCTION_WIDTH 24

// memory map with the entry address as base plus ant id or food index
`define ANT_X_BASE 0
`define ANT_Y_BASE 8
`define FOOD_X_BASE 16
`define FOOD_Y_BASE 20

// instruction layout with the opcode in [1:0]
//   read puts addr in [9:2]
//   write puts addr in [9:2] and data in [17:10]
//   draw puts x in [9:2], y in [16:10], colour in [19:17] and plot in [20]
// all other bits are zero

`endif

// ==== hw/ant_pkg.sv ====
`include "ant_params.svh"

package ant_pkg;

    typedef logic [`X_COORD_WIDTH-1:0]     x_coord_t;
    typedef logic [`Y_COORD_WIDTH-1:0]     y_coord_t;
    typedef logic [`ANT_ID_WIDTH-1:0]      ant_id_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0]    mem_addr_t;
    typedef logic [`RESULT_WIDTH-1:0]      result_t;
    typedef logic [`COLOUR_WIDTH-1:0]      colour_t;
    typedef logic [`INSTRUCTION_WIDTH-1:0] instr_t;
    typedef logic [$clog2(`NUM_FOOD)-1:0]  food_index_t;

    // manhattan distance is one bit wider than x to hold dx + dy
    typedef logic [`X_COORD_WIDTH:0] dist_t;

    typedef enum logic [1:0] {
        OP_MEMREAD  = 2'd0,
        OP_MEMWRITE = 2'd1,
        OP_DRAW     = 2'd2
    } opcode_t;

    typedef enum logic [3:0] {
        U_STANDBY, U_DELAY, U_ANT_X_WAIT, U_ANT_Y_WAIT, U_FOOD_X,
        U_FOOD_X_WAIT, U_FOOD_Y_WAIT, U_STEP, U_SET_X_WAIT, U_SET_Y_WAIT
    } update_state_t;

    typedef enum logic [2:0] {
        D_STANDBY, D_DELAY, D_X_WAIT, D_Y_WAIT, D_PIXEL, D_PIXEL_WAIT
    } draw_state_t;

endpackage

// ==== hw/ant_update.sv ====
`timescale 1ns/1ps
`include "ant_params.svh"

module ant_update
    import ant_pkg::*;
(
    input  logic        clock,
    input  logic        resetn,
    input  logic        start,
    input  ant_id_t     ant_id,
    input  logic        finished_dp,
    input  result_t     result_dp,
    output logic        finished,
    output food_index_t closest_food,
    output logic        start_dp,
    output instr_t      instruction_dp
);

    update_state_t state;
    // wait state entered after the delay step of a command
    update_state_t ret_state;

    x_coord_t    ant_x;
    y_coord_t    ant_y;
    x_coord_t    food_x;
    x_coord_t    best_x;
    y_coord_t    best_y;
    dist_t       best_dist;
    food_index_t food_idx;

    mem_addr_t ant_x_addr;
    mem_addr_t ant_y_addr;
    mem_addr_t food_x_addr;
    mem_addr_t food_y_addr;
    y_coord_t  food_y;
    x_coord_t  dist_x;
    y_coord_t  dist_y;
    dist_t     food_dist;
    x_coord_t  next_x;
    y_coord_t  next_y;

    assign ant_x_addr  = mem_addr_t'(`ANT_X_BASE) + mem_addr_t'(ant_id);
    assign ant_y_addr  = mem_addr_t'(`ANT_Y_BASE) + mem_addr_t'(ant_id);
    assign food_x_addr = mem_addr_t'(`FOOD_X_BASE) + mem_addr_t'(food_idx);
    assign food_y_addr = mem_addr_t'(`FOOD_Y_BASE) + mem_addr_t'(food_idx);

    // distance to the food whose y is arriving on result_dp
    assign food_y    = result_dp[`Y_COORD_WIDTH-1:0];
    assign dist_x    = (food_x > ant_x) ? food_x - ant_x : ant_x - food_x;
    assign dist_y    = (food_y > ant_y) ? food_y - ant_y : ant_y - food_y;
    assign food_dist = dist_t'(dist_x) + dist_t'(dist_y);

    // one step toward the closest food and kept inside the screen
    always_comb begin
        next_x = ant_x;
        next_y = ant_y;
        if (best_x > ant_x && ant_x < x_coord_t'(`SCREEN_WIDTH - `ANT_WIDTH / 2 - 1)) begin
            next_x = ant_x + 1'b1;
        end else if (best_x < ant_x && ant_x > x_coord_t'(`ANT_WIDTH / 2)) begin
            next_x = ant_x - 1'b1;
        end
        if (best_y > ant_y && ant_y < y_coord_t'(`SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1)) begin
            next_y = ant_y + 1'b1;
        end else if (best_y < ant_y && ant_y > y_coord_t'(`ANT_HEIGHT / 2)) begin
            next_y = ant_y - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state          <= U_STANDBY;
            ret_state      <= U_STANDBY;
            finished       <= 1'b1;
            closest_food   <= '0;
            food_idx       <= '0;
            start_dp       <= 1'b0;
            instruction_dp <= '0;
        end else begin
            // start_dp only stays up through the delay step
            start_dp <= 1'b0;
            case (state)
                U_STANDBY: begin
                    if (start) begin
                        finished       <= 1'b0;
                        food_idx       <= '0;
                        best_dist      <= '1;
                        start_dp       <= 1'b1;
                        instruction_dp <= instr_t'({ant_x_addr, OP_MEMREAD});
                        ret_state      <= U_ANT_X_WAIT;
                        state          <= U_DELAY;
                    end
                end
                U_DELAY: begin
                    start_dp <= 1'b1;
                    state    <= ret_state;
                end
                U_ANT_X_WAIT: begin
                    if (finished_dp) begin
                        ant_x          <= result_dp;
                        start_dp       <= 1'b1;
                        instruction_dp <= instr_t'({ant_y_addr, OP_MEMREAD});
                        ret_state      <= U_ANT_Y_WAIT;
                        state          <= U_DELAY;
                    end
                end
                U_ANT_Y_WAIT: begin
                    if (finished_dp) begin
                        ant_y <= result_dp[`Y_COORD_WIDTH-1:0];
                        state <= U_FOOD_X;
                    end
                end
                U_FOOD_X: begin
                    start_dp       <= 1'b1;
                    instruction_dp <= instr_t'({food_x_addr, OP_MEMREAD});
                    ret_state      <= U_FOOD_X_WAIT;
                    state          <= U_DELAY;
                end
                U_FOOD_X_WAIT: begin
                    if (finished_dp) begin
                        food_x         <= result_dp;
                        start_dp       <= 1'b1;
                        instruction_dp <= instr_t'({food_y_addr, OP_MEMREAD});
                        ret_state      <= U_FOOD_Y_WAIT;
                        state          <= U_DELAY;
                    end
                end
                U_FOOD_Y_WAIT: begin
                    if (finished_dp) begin
                        // strict compare so a tie keeps the lower index
                        if (food_dist < best_dist) begin
                            best_dist    <= food_dist;
                            best_x       <= food_x;
                            best_y       <= food_y;
                            closest_food <= food_idx;
                        end
                        food_idx <= food_idx + 1'b1;
                        if (food_idx == food_index_t'(`NUM_FOOD - 1)) begin
                            state <= U_STEP;
                        end else begin
                            state <= U_FOOD_X;
                        end
                    end
                end
                U_STEP: begin
                    ant_x          <= next_x;
                    ant_y          <= next_y;
                    start_dp       <= 1'b1;
                    instruction_dp <= instr_t'({result_t'(next_x), ant_x_addr, OP_MEMWRITE});
                    ret_state      <= U_SET_X_WAIT;
                    state          <= U_DELAY;
                end
                U_SET_X_WAIT: begin
                    if (finished_dp) begin
                        start_dp       <= 1'b1;
                        instruction_dp <= instr_t'({result_t'(ant_y), ant_y_addr, OP_MEMWRITE});
                        ret_state      <= U_SET_Y_WAIT;
                        state          <= U_DELAY;
                    end
                end
                U_SET_Y_WAIT: begin
                    if (finished_dp) begin
                        finished <= 1'b1;
                        state    <= U_STANDBY;
                    end
                end
                default: state <= U_STANDBY;
            endcase
        end
    end

endmodule

// ==== hw/dp_arbiter.sv ====
`timescale 1ns/1ps

module dp_arbiter
    import ant_pkg::*;
(
    input  logic    clock,
    input  logic    resetn,
    input  logic    update_start_dp,
    input  instr_t  update_instruction,
    input  logic    draw_start_dp,
    input  instr_t  draw_instruction,
    input  logic    finished_dp,
    input  result_t result_dp,
    output logic    update_finished_dp,
    output result_t update_result,
    output logic    draw_finished_dp,
    output result_t draw_result,
    output logic    start_dp,
    output instr_t  instruction_dp
);

    logic   upd_start_q;
    logic   drw_start_q;
    logic   upd_pend;
    logic   drw_pend;
    instr_t upd_slot;
    instr_t drw_slot;
    logic   busy;
    logic   owner_draw;
    logic   issue_left;
    logic   upd_capture;
    logic   drw_capture;

    // a client command is taken on the first cycle of its start pulse
    assign upd_capture = update_start_dp & ~upd_start_q;
    assign drw_capture = draw_start_dp & ~drw_start_q;

    assign update_finished_dp = finished_dp & busy & ~owner_draw;
    assign draw_finished_dp   = finished_dp & busy & owner_draw;
    assign update_result      = (busy && !owner_draw) ? result_dp : '0;
    assign draw_result        = (busy && owner_draw) ? result_dp : '0;

    always_ff @(posedge clock) begin
        if (upd_capture) begin
            upd_slot <= update_instruction;
        end
        if (drw_capture) begin
            drw_slot <= draw_instruction;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            upd_start_q    <= 1'b0;
            drw_start_q    <= 1'b0;
            upd_pend       <= 1'b0;
            drw_pend       <= 1'b0;
            busy           <= 1'b0;
            owner_draw     <= 1'b0;
            issue_left     <= 1'b0;
            start_dp       <= 1'b0;
            instruction_dp <= '0;
        end else begin
            upd_start_q <= update_start_dp;
            drw_start_q <= draw_start_dp;

            // start and delay cycles on the external bus
            if (start_dp) begin
                if (issue_left) begin
                    issue_left <= 1'b0;
                end else begin
                    start_dp <= 1'b0;
                end
            end

            if (busy && finished_dp) begin
                busy <= 1'b0;
                if (owner_draw) begin
                    drw_pend <= 1'b0;
                end else begin
                    upd_pend <= 1'b0;
                end
            end else if (!busy && (upd_pend || drw_pend)) begin
                // update wins when both slots wait
                busy           <= 1'b1;
                owner_draw     <= ~upd_pend;
                start_dp       <= 1'b1;
                issue_left     <= 1'b1;
                instruction_dp <= upd_pend ? upd_slot : drw_slot;
            end

            if (upd_capture) begin
                upd_pend <= 1'b1;
            end
            if (drw_capture) begin
                drw_pend <= 1'b1;
            end
        end
    end

endmodule

// ==== testbench/ant_engine_properties.sv ====
`timescale 1ns/1ps

module ant_engine_properties
    import ant_pkg::*;
(
    input logic   clock,
    input logic   resetn,
    input logic   start_dp,
    input logic   finished_dp,
    input logic   update_finished,
    input logic   draw_finished,
    input instr_t instruction_dp
);

    int fail_count = 0;

    // a command has been issued and its finished pulse has not yet come
    logic in_flight;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            in_flight <= 1'b0;
        end else if (finished_dp) begin
            in_flight <= 1'b0;
        end else if (start_dp) begin
            in_flight <= 1'b1;
        end
    end

    start_two_cycles: assert property (@(posedge clock) disable iff (!resetn)
        start_dp && $past(start_dp) |=> !start_dp)
        else begin
            fail_count = fail_count + 1;
            $error("start_dp high for three cycles");
        end

    instr_held: assert property (@(posedge clock) disable iff (!resetn)
        in_flight |-> $stable(instruction_dp))
        else begin
            fail_count = fail_count + 1;
            $error("instruction_dp changed before finished_dp");
        end

    idle_after_reset: assert property (@(posedge clock)
        !resetn |=> update_finished && draw_finished)
        else begin
            fail_count = fail_count + 1;
            $error("finished outputs low after reset");
        end

endmodule

// ==== testbench/tb_ant_engine.sv ====
`timescale 1ns/1ps
`include "ant_params.svh"

module tb_ant_engine
    import ant_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic        clock;
    logic        resetn;
    logic        update_start;
    logic        draw_start;
    ant_id_t     ant_id;
    logic        finished_dp = 1'b0;
    result_t     result_dp = '0;
    logic        update_finished;
    logic        draw_finished;
    food_index_t closest_food;
    logic        start_dp;
    instr_t      instruction_dp;

    integer  seed = 60;
    result_t mem [0:255];
    instr_t  cmd_log[$];
    instr_t  draw_log[$];
    int      delay = 0;
    logic    start_q = 1'b0;

    ant_engine i_ant_engine (
        .clock           (clock),
        .resetn          (resetn),
        .update_start    (update_start),
        .draw_start      (draw_start),
        .ant_id          (ant_id),
        .finished_dp     (finished_dp),
        .result_dp       (result_dp),
        .update_finished (update_finished),
        .draw_finished   (draw_finished),
        .closest_food    (closest_food),
        .start_dp        (start_dp),
        .instruction_dp  (instruction_dp)
    );

    bind ant_engine ant_engine_properties i_ant_engine_properties (
        .clock           (clock),
        .resetn          (resetn),
        .start_dp        (start_dp),
        .finished_dp     (finished_dp),
        .update_finished (update_finished),
        .draw_finished   (draw_finished),
        .instruction_dp  (instruction_dp)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_x(input string name, input x_coord_t got, input x_coord_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_y(input string name, input y_coord_t got, input y_coord_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_food(input string name, input food_index_t got,
                              input food_index_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // datapath model answers one command a random 1 to 8 cycles after start_dp falls
    task automatic execute_command();
        instr_t ins;
        ins = instruction_dp;
        cmd_log.push_back(ins);
        case (ins[1:0])
            OP_MEMREAD:  result_dp = mem[ins[9:2]];
            OP_MEMWRITE: mem[ins[9:2]] = ins[17:10];
            OP_DRAW:     draw_log.push_back(ins);
            default:     stop_run($sformatf("unknown opcode in command 0x%h", ins));
        endcase
        finished_dp = 1'b1;
    endtask

    always @(negedge clock) begin
        finished_dp = 1'b0;
        result_dp   = '0;
        if (!resetn) begin
            delay   = 0;
            start_q = 1'b0;
        end else begin
            if (delay != 0) begin
                delay = delay - 1;
                if (delay == 0) begin
                    execute_command();
                end
            end
            if (start_q && !start_dp) begin
                delay = 1 + ({$random(seed)} % 8);
            end
            start_q = start_dp;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    function automatic instr_t read_instr(input int addr);
        instr_t ins;
        ins = '0;
        ins[1:0] = OP_MEMREAD;
        ins[9:2] = addr[7:0];
        return ins;
    endfunction

    function automatic instr_t pixel_instr(input x_coord_t x, input y_coord_t y);
        instr_t ins;
        ins = '0;
        ins[1:0]   = OP_DRAW;
        ins[9:2]   = x;
        ins[16:10] = y;
        ins[19:17] = `ANT_COLOUR;
        ins[20]    = 1'b1;
        return ins;
    endfunction

    // nearest food by manhattan distance where the first index wins a tie
    function automatic food_index_t nearest_food(input ant_id_t id);
        int ax;
        int ay;
        int fx;
        int fy;
        int d;
        int best;
        food_index_t idx;
        ax   = mem[`ANT_X_BASE + id];
        ay   = mem[`ANT_Y_BASE + id];
        best = 1 << 30;
        idx  = '0;
        for (int i = 0; i < `NUM_FOOD; i++) begin
            fx = mem[`FOOD_X_BASE + i];
            fy = mem[`FOOD_Y_BASE + i];
            d  = ((fx > ax) ? fx - ax : ax - fx) + ((fy > ay) ? fy - ay : ay - fy);
            if (d < best) begin
                best = d;
                idx  = food_index_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic int step_coord(input int a, input int target, input int size,
                                      input int screen);
        if (target > a && a < screen - size / 2 - 1) begin
            return a + 1;
        end
        if (target < a && a > size / 2) begin
            return a - 1;
        end
        return a;
    endfunction

    function automatic int expected_coord(input ant_id_t id, input bit y_axis);
        food_index_t f;
        f = nearest_food(id);
        if (y_axis) begin
            return step_coord(mem[`ANT_Y_BASE + id], mem[`FOOD_Y_BASE + f],
                              `ANT_HEIGHT, `SCREEN_HEIGHT);
        end
        return step_coord(mem[`ANT_X_BASE + id], mem[`FOOD_X_BASE + f],
                          `ANT_WIDTH, `SCREEN_WIDTH);
    endfunction

    task automatic place_random(input ant_id_t id);
        mem[`ANT_X_BASE + id] = result_t'(rand_range(`ANT_WIDTH / 2,
                                                     `SCREEN_WIDTH - `ANT_WIDTH / 2 - 1));
        mem[`ANT_Y_BASE + id] = result_t'(rand_range(`ANT_HEIGHT / 2,
                                                     `SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1));
        for (int i = 0; i < `NUM_FOOD; i++) begin
            mem[`FOOD_X_BASE + i] = result_t'(rand_range(0, `SCREEN_WIDTH - 1));
            mem[`FOOD_Y_BASE + i] = result_t'(rand_range(0, `SCREEN_HEIGHT - 1));
        end
    endtask

    task automatic wait_finished(input bit draw_side, input logic level);
        int cycles;
        cycles = 0;
        while ((draw_side ? draw_finished : update_finished) !== level) begin
            if (cycles == TIMEOUT) begin
                stop_run($sformatf("timed out waiting for %s finished to go %0d",
                                   draw_side ? "draw" : "update", level));
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic pulse_start(input logic upd, input logic drw);
        update_start = upd;
        draw_start   = drw;
        @(negedge clock);
        update_start = 1'b0;
        draw_start   = 1'b0;
    endtask

    // 16 pixels in row-major order with column fastest
    task automatic check_sprite(input x_coord_t ox, input y_coord_t oy);
        int k;
        if (draw_log.size() != `ANT_WIDTH * `ANT_HEIGHT) begin
            stop_run($sformatf("expected 16 draw commands but saw %0d", draw_log.size()));
        end
        k = 0;
        for (int r = 0; r < `ANT_HEIGHT; r++) begin
            for (int c = 0; c < `ANT_WIDTH; c++) begin
                check_instr($sformatf("draw[%0d]", k), draw_log[k],
                            pixel_instr(x_coord_t'(ox + c), y_coord_t'(oy + r)));
                k++;
            end
        end
    endtask

    task automatic update_and_check(input ant_id_t id);
        food_index_t ef;
        x_coord_t    ex;
        y_coord_t    ey;
        ef     = nearest_food(id);
        ex     = x_coord_t'(expected_coord(id, 1'b0));
        ey     = y_coord_t'(expected_coord(id, 1'b1));
        ant_id = id;
        pulse_start(1'b1, 1'b0);
        wait_finished(1'b0, 1'b0);
        wait_finished(1'b0, 1'b1);
        check_food("closest_food", closest_food, ef);
        check_x("ant_x", x_coord_t'(mem[`ANT_X_BASE + id]), ex);
        check_y("ant_y", y_coord_t'(mem[`ANT_Y_BASE + id]), ey);
    endtask

    // ant on a screen bound with every food beyond it on that axis
    task automatic edge_case(input ant_id_t id, input bit y_axis, input bit upper);
        int hold;
        place_random(id);
        for (int i = 0; i < `NUM_FOOD; i++) begin
            if (y_axis) begin
                mem[`FOOD_Y_BASE + i] = upper ? `SCREEN_HEIGHT - 1 : 0;
            end else begin
                mem[`FOOD_X_BASE + i] = upper ? `SCREEN_WIDTH - 1 : 0;
            end
        end
        if (y_axis) begin
            mem[`ANT_Y_BASE + id] = upper ? `SCREEN_HEIGHT - `ANT_HEIGHT / 2 - 1
                                          : `ANT_HEIGHT / 2;
            hold = mem[`ANT_Y_BASE + id];
        end else begin
            mem[`ANT_X_BASE + id] = upper ? `SCREEN_WIDTH - `ANT_WIDTH / 2 - 1
                                          : `ANT_WIDTH / 2;
            hold = mem[`ANT_X_BASE + id];
        end
        update_and_check(id);
        if (y_axis) begin
            check_y("ant_y at bound", y_coord_t'(mem[`ANT_Y_BASE + id]), y_coord_t'(hold));
        end else begin
            check_x("ant_x at bound", x_coord_t'(mem[`ANT_X_BASE + id]), x_coord_t'(hold));
        end
    endtask

    task automatic draw_and_check(input ant_id_t id);
        x_coord_t ox;
        y_coord_t oy;
        place_random(id);
        draw_log.delete();
        ox     = x_coord_t'(mem[`ANT_X_BASE + id] - 1);
        oy     = y_coord_t'(mem[`ANT_Y_BASE + id] - 1);
        ant_id = id;
        pulse_start(1'b0, 1'b1);
        wait_finished(1'b1, 1'b0);
        wait_finished(1'b1, 1'b1);
        check_sprite(ox, oy);
    endtask

    task automatic both_and_check(input ant_id_t id);
        x_coord_t    ox;
        y_coord_t    oy;
        x_coord_t    ex;
        y_coord_t    ey;
        food_index_t ef;
        place_random(id);
        ox = x_coord_t'(mem[`ANT_X_BASE + id] - 1);
        oy = y_coord_t'(mem[`ANT_Y_BASE + id] - 1);
        ef = nearest_food(id);
        ex = x_coord_t'(expected_coord(id, 1'b0));
        ey = y_coord_t'(expected_coord(id, 1'b1));
        cmd_log.delete();
        draw_log.delete();
        ant_id = id;
        pulse_start(1'b1, 1'b1);
        wait_finished(1'b0, 1'b0);
        wait_finished(1'b1, 1'b0);
        wait_finished(1'b0, 1'b1);
        wait_finished(1'b1, 1'b1);
        if (cmd_log.size() < 5) begin
            stop_run("fewer than five commands were seen on the datapath bus");
        end
        check_instr("first bus command", cmd_log[0], read_instr(`ANT_X_BASE + id));
        // both slots wait again once the position reads are done, so update goes first
        check_instr("fifth bus command", cmd_log[4], read_instr(`FOOD_X_BASE));
        check_food("closest_food", closest_food, ef);
        check_x("ant_x", x_coord_t'(mem[`ANT_X_BASE + id]), ex);
        check_y("ant_y", y_coord_t'(mem[`ANT_Y_BASE + id]), ey);
        // sprite drawn from either the old or the new position
        if (draw_log.size() > 0 && draw_log[0] == pixel_instr(ox, oy)) begin
            check_sprite(ox, oy);
        end else begin
            check_sprite(ex - 1'b1, ey - 1'b1);
        end
    endtask

    initial begin
        ant_id_t pick;
        resetn       = 1'b0;
        update_start = 1'b0;
        draw_start   = 1'b0;
        ant_id       = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = result_t'(a * 37 + 11);
        end
        repeat (16) @(negedge clock);
        resetn = 1'b1;

        check_bit("update_finished", update_finished, 1'b1);
        check_bit("draw_finished", draw_finished, 1'b1);
        check_bit("start_dp", start_dp, 1'b0);
        check_instr("instruction_dp", instruction_dp, '0);

        for (int n = 0; n < 20; n++) begin
            pick = ant_id_t'(rand_range(0, 7));
            place_random(pick);
            update_and_check(pick);
        end
        for (int e = 0; e < 4; e++) begin
            edge_case(ant_id_t'(rand_range(0, 7)), e[1], e[0]);
        end
        for (int n = 0; n < 4; n++) begin
            draw_and_check(ant_id_t'(rand_range(0, 7)));
        end
        for (int n = 0; n < 4; n++) begin
            both_and_check(ant_id_t'(rand_range(0, 7)));
        end

        if (i_ant_engine.i_ant_engine_properties.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run("bound assertions reported failures");
        end
    end

endmodule
